/* list.f */
design/bayer_pkg.sv
design/bayer_window_5x5.sv
design/bayer_gaussian_calc.sv
design/frame_sync_delay.sv
design/bayer_gaussian_core.sv
+incdir+bench
bench/tb_bayer_gaussian.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log
set -u
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_bayer_gaussian -f list.f -o sim_bayer
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_bayer 2>&1 | tee sim.log
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

/* bench/bayer_model.svh */
`ifndef BAYER_MODEL_SVH
`define BAYER_MODEL_SVH

// frame currently in flight, filled before it is sent
logic [RAW_BITS-1:0] img [MAX_DIM][MAX_DIM];
int                  img_rows;
int                  img_cols;

// mirror about the edge sample
function automatic int reflect(input int x, input int n);
    if (x < 0)
        return -x;
    if (x > n - 1)
        return 2 * (n - 1) - x;
    return x;
endfunction

// 1-2-1 kernel tap
function automatic int tap_weight(input int k);
    return (k == 0) ? 2 : 1;
endfunction

function automatic int expected_pixel(input int r, input int c, input bit en);
    int acc;
    int rr;
    int cc;
    if (!en)
        return int'(img[r][c]);
    acc = 0;
    for (int i = -1; i <= 1; i++) begin
        for (int j = -1; j <= 1; j++) begin
            rr  = reflect(r + 2 * i, img_rows);  // same colour sits two samples away
            cc  = reflect(c + 2 * j, img_cols);
            acc = acc + tap_weight(i) * tap_weight(j) * int'(img[rr][cc]);
        end
    end
    return (acc + 8) >>> 4;
endfunction

`endif

/* bench/tb_bayer_gaussian.sv */
`default_nettype none

module tb_bayer_gaussian;
    import bayer_pkg::*;

    localparam int PERIOD     = 40;
    localparam int NUM_FRAMES = 13;
    localparam int MIN_DIM    = 3;
    localparam int MAX_DIM    = 16;
    localparam int SEED       = 32'hfe8c;
    localparam int GAP_BEATS  = 24;   // flush allowance per frame

    `include "bayer_model.svh"

    logic                 clk;
    logic                 rst_n;
    logic                 cke;
    logic                 enable;
    logic [ROWS_BITS-1:0] s_rows;
    logic [COLS_BITS-1:0] s_cols;
    logic                 s_row_first;
    logic                 s_row_last;
    logic                 s_col_first;
    logic                 s_col_last;
    logic                 s_de;
    logic [USER_BITS-1:0] s_user;
    logic [RAW_BITS-1:0]  s_data;
    logic                 s_valid;
    logic [ROWS_BITS-1:0] m_rows;
    logic [COLS_BITS-1:0] m_cols;
    logic                 m_row_first;
    logic                 m_row_last;
    logic                 m_col_first;
    logic                 m_col_last;
    logic                 m_de;
    logic [USER_BITS-1:0] m_user;
    logic [RAW_BITS-1:0]  m_data;
    logic                 m_valid;

    int                   plan_rows [NUM_FRAMES];
    int                   plan_cols [NUM_FRAMES];
    int                   err_count;
    int                   checked;
    int                   frame_idx;
    int                   pix_count;
    int                   exp_r;
    int                   exp_c;
    int                   wd_beats;
    logic [USER_BITS-1:0] frame_user;
    bit                   frame_en;
    bit                   stall_on;
    bit                   started;

    bayer_gaussian_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cke         (cke),
        .enable      (enable),
        .s_rows      (s_rows),
        .s_cols      (s_cols),
        .s_row_first (s_row_first),
        .s_row_last  (s_row_last),
        .s_col_first (s_col_first),
        .s_col_last  (s_col_last),
        .s_de        (s_de),
        .s_user      (s_user),
        .s_data      (s_data),
        .s_valid     (s_valid),
        .m_rows      (m_rows),
        .m_cols      (m_cols),
        .m_row_first (m_row_first),
        .m_row_last  (m_row_last),
        .m_col_first (m_col_first),
        .m_col_last  (m_col_last),
        .m_de        (m_de),
        .m_user      (m_user),
        .m_data      (m_data),
        .m_valid     (m_valid)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic string test_name(input int f);
        if (f < 4)
            return "filter";
        if (f < 8)
            return "border";
        if (f < 10)
            return "bypass";
        return "stall";
    endfunction

    task automatic report_mismatch(input string field, input int expected, input int actual);
        err_count++;
        $display("** Error [%s] frame %0d pixel (%0d,%0d) %s: expected %0d, actual %0d",
                 test_name(frame_idx), frame_idx, exp_r, exp_c, field, expected, actual);
    endtask

    task automatic plan_frames();
        int total;
        total = 10;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            plan_rows[f] = int'($urandom_range(MIN_DIM, MAX_DIM));
            plan_cols[f] = int'($urandom_range(MIN_DIM, MAX_DIM));
        end
        plan_rows[4] = 3;   // thinnest frames the reflection allows
        plan_cols[5] = 3;
        plan_rows[6] = 3;
        plan_cols[6] = 3;
        for (int f = 0; f < NUM_FRAMES; f++)
            total = total + (plan_rows[f] + VBLANK_LINES) * (plan_cols[f] + HBLANK) + GAP_BEATS;
        wd_beats = total;
    endtask

    task automatic fill_image(input int f);
        bit near_corner;
        img_rows = plan_rows[f];
        img_cols = plan_cols[f];
        for (int r = 0; r < img_rows; r++) begin
            for (int c = 0; c < img_cols; c++) begin
                near_corner = (r < 2 || r >= img_rows - 2) && (c < 2 || c >= img_cols - 2);
                if (test_name(f) == "border" && near_corner)
                    img[r][c] = {RAW_BITS{1'b1}};
                else
                    img[r][c] = RAW_BITS'($urandom);
            end
        end
    endtask

    // hold the beat until a cycle with cke high takes it
    task automatic drive_beat(input bit de, input bit rf, input bit rl, input bit cf,
                              input bit cl, input logic [RAW_BITS-1:0] data);
        bit ce;
        ce = 1'b0;
        while (!ce) begin
            ce = stall_on ? ($urandom_range(0, 3) != 0) : 1'b1;
            s_valid     <= 1'b1;
            s_de        <= de;
            s_row_first <= rf;
            s_row_last  <= rl;
            s_col_first <= cf;
            s_col_last  <= cl;
            s_data      <= data;
            cke         <= ce;
            @(posedge clk);
        end
    endtask

    task automatic run_frame(input int f);
        int rows;
        int cols;
        int waited;
        rows = plan_rows[f];
        cols = plan_cols[f];
        fill_image(f);
        frame_idx  = f;
        pix_count  = 0;
        exp_r      = 0;
        exp_c      = 0;
        frame_en   = (test_name(f) != "bypass");
        stall_on   = (test_name(f) == "stall");
        frame_user = USER_BITS'($urandom);
        enable <= frame_en;
        s_rows <= ROWS_BITS'(rows);
        s_cols <= COLS_BITS'(cols);
        s_user <= frame_user;
        started = 1'b1;
        for (int y = 0; y < rows + VBLANK_LINES; y++) begin
            for (int x = 0; x < cols + HBLANK; x++) begin
                if (y < rows && x < cols)
                    drive_beat(1'b1, y == 0, y == rows - 1, x == 0, x == cols - 1, img[y][x]);
                else
                    drive_beat(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, RAW_BITS'($urandom));
            end
        end
        stall_on = 1'b0;
        s_valid <= 1'b0;
        s_de    <= 1'b0;
        cke     <= 1'b1;
        waited = 0;
        while (pix_count < rows * cols && waited < GAP_BEATS) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);   // catch any surplus pixel
        if (pix_count != rows * cols) begin
            err_count++;
            $display("frame %0d (%s) produced %0d output pixels instead of %0d",
                     f, test_name(f), pix_count, rows * cols);
        end
    endtask

    task automatic check_pixel();
        int rows;
        int cols;
        int exp_data;
        rows = plan_rows[frame_idx];
        cols = plan_cols[frame_idx];
        if (pix_count >= rows * cols) begin
            err_count++;
            $display("frame %0d sent a pixel beyond its %0d expected pixels", frame_idx,
                     rows * cols);
            return;
        end
        exp_data = expected_pixel(exp_r, exp_c, frame_en);
        if (int'(m_data) != exp_data)
            report_mismatch("data", exp_data, int'(m_data));
        if (m_row_first != (exp_r == 0))
            report_mismatch("row_first", int'(exp_r == 0), int'(m_row_first));
        if (m_row_last != (exp_r == rows - 1))
            report_mismatch("row_last", int'(exp_r == rows - 1), int'(m_row_last));
        if (m_col_first != (exp_c == 0))
            report_mismatch("col_first", int'(exp_c == 0), int'(m_col_first));
        if (m_col_last != (exp_c == cols - 1))
            report_mismatch("col_last", int'(exp_c == cols - 1), int'(m_col_last));
        if (int'(m_rows) != rows)
            report_mismatch("rows", rows, int'(m_rows));
        if (int'(m_cols) != cols)
            report_mismatch("cols", cols, int'(m_cols));
        if (m_user != frame_user)
            report_mismatch("user", int'(frame_user), int'(m_user));
        pix_count++;
        checked++;
        if (exp_c == cols - 1) begin
            exp_c = 0;
            exp_r++;
        end else begin
            exp_c++;
        end
    endtask

    // outputs are stable at the falling edge, cke says whether the beat is taken next
    always @(negedge clk) begin
        if (rst_n && !started && (m_valid || m_de)) begin
            err_count++;
            $display("output strobes went high before any frame was sent");
        end
        if (started && cke && m_valid && m_de)
            check_pixel();
    end

    initial begin
        wait (wd_beats > 0);
        #(wd_beats * 3 * PERIOD);
        $display("watchdog expired after %0d beats, the DUT stopped producing pixels",
                 wd_beats * 3);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        err_count   = 0;
        checked     = 0;
        frame_idx   = 0;
        pix_count   = 0;
        exp_r       = 0;
        exp_c       = 0;
        wd_beats    = 0;
        frame_user  = '0;
        frame_en    = 1'b1;
        stall_on    = 1'b0;
        started     = 1'b0;
        rst_n       = 1'b0;
        cke         = 1'b1;
        enable      = 1'b1;
        s_rows      = '0;
        s_cols      = '0;
        s_row_first = 1'b0;
        s_row_last  = 1'b0;
        s_col_first = 1'b0;
        s_col_last  = 1'b0;
        s_de        = 1'b0;
        s_user      = '0;
        s_data      = '0;
        s_valid     = 1'b0;
        plan_frames();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);   // idle, strobes must stay low
        for (int f = 0; f < NUM_FRAMES; f++)
            run_frame(f);
        $display("checked %0d pixels in %0d frames, %0d errors", checked, NUM_FRAMES,
                 err_count);
        if (err_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* design/bayer_gaussian_core.sv */
`default_nettype none

module bayer_gaussian_core #(
    parameter bit ROUND = 1'b1
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cke,
    input  logic                             enable,     // low passes the centre sample through
    input  logic [bayer_pkg::ROWS_BITS-1:0]  s_rows,
    input  logic [bayer_pkg::COLS_BITS-1:0]  s_cols,
    input  logic                             s_row_first,
    input  logic                             s_row_last,
    input  logic                             s_col_first,
    input  logic                             s_col_last,
    input  logic                             s_de,
    input  logic [bayer_pkg::USER_BITS-1:0]  s_user,
    input  logic [bayer_pkg::RAW_BITS-1:0]   s_data,
    input  logic                             s_valid,
    output logic [bayer_pkg::ROWS_BITS-1:0]  m_rows,
    output logic [bayer_pkg::COLS_BITS-1:0]  m_cols,
    output logic                             m_row_first,
    output logic                             m_row_last,
    output logic                             m_col_first,
    output logic                             m_col_last,
    output logic                             m_de,
    output logic [bayer_pkg::USER_BITS-1:0]  m_user,
    output logic [bayer_pkg::RAW_BITS-1:0]   m_data,
    output logic                             m_valid
);
    import bayer_pkg::*;

    logic [ROWS_BITS-1:0] win_rows;
    logic [COLS_BITS-1:0] win_cols;
    logic                 win_row_first;
    logic                 win_row_last;
    logic                 win_col_first;
    logic                 win_col_last;
    logic                 win_de;
    logic [USER_BITS-1:0] win_user;
    logic [WIN_SIZE-1:0][WIN_SIZE-1:0][RAW_BITS-1:0] win_raw;
    logic                 win_valid;

    bayer_window_5x5 u_window (
        .clk           (clk),
        .rst_n         (rst_n),
        .cke           (cke),
        .s_rows        (s_rows),
        .s_cols        (s_cols),
        .s_row_first   (s_row_first),
        .s_row_last    (s_row_last),
        .s_col_first   (s_col_first),
        .s_col_last    (s_col_last),
        .s_de          (s_de),
        .s_user        (s_user),
        .s_data        (s_data),
        .s_valid       (s_valid),
        .win_rows      (win_rows),
        .win_cols      (win_cols),
        .win_row_first (win_row_first),
        .win_row_last  (win_row_last),
        .win_col_first (win_col_first),
        .win_col_last  (win_col_last),
        .win_de        (win_de),
        .win_user      (win_user),
        .win_raw       (win_raw),
        .win_valid     (win_valid)
    );

    bayer_gaussian_calc #(
        .ROUND (ROUND)
    ) u_calc (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .enable  (enable),
        .win_raw (win_raw),
        .m_data  (m_data)
    );

    // sideband waits out the arithmetic
    frame_sync_delay #(
        .LATENCY (CALC_LATENCY)
    ) u_delay (
        .clk           (clk),
        .rst_n         (rst_n),
        .cke           (cke),
        .win_rows      (win_rows),
        .win_cols      (win_cols),
        .win_row_first (win_row_first),
        .win_row_last  (win_row_last),
        .win_col_first (win_col_first),
        .win_col_last  (win_col_last),
        .win_de        (win_de),
        .win_user      (win_user),
        .win_valid     (win_valid),
        .m_rows        (m_rows),
        .m_cols        (m_cols),
        .m_row_first   (m_row_first),
        .m_row_last    (m_row_last),
        .m_col_first   (m_col_first),
        .m_col_last    (m_col_last),
        .m_de          (m_de),
        .m_user        (m_user),
        .m_valid       (m_valid)
    );

endmodule

`default_nettype wire

/* design/frame_sync_delay.sv */
`default_nettype none

module frame_sync_delay #(
    parameter int LATENCY = bayer_pkg::CALC_LATENCY
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cke,
    input  logic [bayer_pkg::ROWS_BITS-1:0]  win_rows,
    input  logic [bayer_pkg::COLS_BITS-1:0]  win_cols,
    input  logic                             win_row_first,
    input  logic                             win_row_last,
    input  logic                             win_col_first,
    input  logic                             win_col_last,
    input  logic                             win_de,
    input  logic [bayer_pkg::USER_BITS-1:0]  win_user,
    input  logic                             win_valid,
    output logic [bayer_pkg::ROWS_BITS-1:0]  m_rows,
    output logic [bayer_pkg::COLS_BITS-1:0]  m_cols,
    output logic                             m_row_first,
    output logic                             m_row_last,
    output logic                             m_col_first,
    output logic                             m_col_last,
    output logic                             m_de,
    output logic [bayer_pkg::USER_BITS-1:0]  m_user,
    output logic                             m_valid
);
    import bayer_pkg::*;

    logic [ROWS_BITS-1:0] rows_q [LATENCY];
    logic [COLS_BITS-1:0] cols_q [LATENCY];
    logic [USER_BITS-1:0] user_q [LATENCY];
    logic [3:0]           flag_q [LATENCY];    // row_first, row_last, col_first, col_last
    logic [LATENCY-1:0]   de_q;
    logic [LATENCY-1:0]   valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_q    <= '0;
            valid_q <= '0;
        end else if (cke) begin
            de_q    <= {de_q[LATENCY-2:0], win_de};
            valid_q <= {valid_q[LATENCY-2:0], win_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            rows_q[0] <= win_rows;
            cols_q[0] <= win_cols;
            user_q[0] <= win_user;
            flag_q[0] <= {win_row_first, win_row_last, win_col_first, win_col_last};
            for (int i = 1; i < LATENCY; i++) begin
                rows_q[i] <= rows_q[i-1];
                cols_q[i] <= cols_q[i-1];
                user_q[i] <= user_q[i-1];
                flag_q[i] <= flag_q[i-1];
            end
        end
    end

    assign m_rows = rows_q[LATENCY-1];
    assign m_cols = cols_q[LATENCY-1];
    assign m_user = user_q[LATENCY-1];
    assign {m_row_first, m_row_last, m_col_first, m_col_last} = flag_q[LATENCY-1];
    assign m_de    = de_q[LATENCY-1];
    assign m_valid = valid_q[LATENCY-1];

    // de from the window is only ever set on a consumed beat
    a_de_valid: assert property (@(posedge clk) disable iff (!rst_n)
        m_de |-> m_valid);

endmodule

`default_nettype wire

/* design/bayer_gaussian_calc.sv */
`default_nettype none

module bayer_gaussian_calc #(
    parameter bit ROUND = 1'b1
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cke,
    input  logic                                  enable,
    input  logic [bayer_pkg::WIN_SIZE-1:0][bayer_pkg::WIN_SIZE-1:0][bayer_pkg::RAW_BITS-1:0]
                                                  win_raw,
    output logic [bayer_pkg::RAW_BITS-1:0]        m_data
);
    import bayer_pkg::*;

    logic [ROW_SUM_BITS-1:0] row_sum [3];      // rows -2, 0, +2
    logic [SUM_BITS-1:0]     sum;
    logic [SUM_BITS:0]       rnd;
    logic [RAW_BITS:0]       res;
    logic [RAW_BITS-1:0]     ctr_pipe [CALC_LATENCY-1];
    logic [CALC_LATENCY-2:0] en_pipe;

    // only even offsets share the centre's colour
    always_ff @(posedge clk) begin
        if (cke) begin
            for (int k = 0; k < 3; k++) begin
                row_sum[k] <= ROW_SUM_BITS'(win_raw[2*k][0]) +
                              ROW_SUM_BITS'({win_raw[2*k][2], 1'b0}) +
                              ROW_SUM_BITS'(win_raw[2*k][4]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cke)
            sum <= SUM_BITS'(row_sum[0]) + SUM_BITS'({row_sum[1], 1'b0}) + SUM_BITS'(row_sum[2]);
    end

    assign rnd = {1'b0, sum} + {{(SUM_BITS - 3){1'b0}}, ROUND, 3'b000};

    always_ff @(posedge clk) begin
        if (cke)
            res <= rnd[SUM_BITS:4];  // divide by 16
    end

    // centre and enable follow the arithmetic
    always_ff @(posedge clk) begin
        if (cke) begin
            ctr_pipe[0] <= win_raw[2][2];
            for (int i = 1; i < CALC_LATENCY - 1; i++)
                ctr_pipe[i] <= ctr_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            en_pipe <= '0;
        else if (cke)
            en_pipe <= {en_pipe[CALC_LATENCY-3:0], enable};
    end

    always_ff @(posedge clk) begin
        if (cke)
            m_data <= en_pipe[CALC_LATENCY-2] ? res[RAW_BITS-1:0] : ctr_pipe[CALC_LATENCY-2];
    end

    // weights total 16, so the mean stays in range
    a_res_range: assert property (@(posedge clk) disable iff (!rst_n)
        !res[RAW_BITS]);

endmodule

`default_nettype wire

/* design/bayer_window_5x5.sv */
`default_nettype none

module bayer_window_5x5 (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cke,
    input  logic [bayer_pkg::ROWS_BITS-1:0]       s_rows,
    input  logic [bayer_pkg::COLS_BITS-1:0]       s_cols,
    input  logic                                  s_row_first,
    input  logic                                  s_row_last,
    input  logic                                  s_col_first,
    input  logic                                  s_col_last,
    input  logic                                  s_de,
    input  logic [bayer_pkg::USER_BITS-1:0]       s_user,
    input  logic [bayer_pkg::RAW_BITS-1:0]        s_data,
    input  logic                                  s_valid,
    output logic [bayer_pkg::ROWS_BITS-1:0]       win_rows,
    output logic [bayer_pkg::COLS_BITS-1:0]       win_cols,
    output logic                                  win_row_first,
    output logic                                  win_row_last,
    output logic                                  win_col_first,
    output logic                                  win_col_last,
    output logic                                  win_de,
    output logic [bayer_pkg::USER_BITS-1:0]       win_user,
    output logic [bayer_pkg::WIN_SIZE-1:0][bayer_pkg::WIN_SIZE-1:0][bayer_pkg::RAW_BITS-1:0]
                                                  win_raw,
    output logic                                  win_valid
);
    import bayer_pkg::*;

    win_state_t               state;
    logic [X_BITS-1:0]        cnt_x;
    logic [Y_BITS-1:0]        cnt_y;
    logic [ROWS_BITS-1:0]     frm_rows;
    logic [COLS_BITS-1:0]     frm_cols;
    logic                     sof;
    logic                     advance;
    logic                     line_end;
    logic                     wr_en;
    logic [MEM_ADDR_BITS-1:0] mem_addr;
    logic [WORD_BITS-1:0]     line_mem [WIN_SIZE-1][MAX_COLS];
    logic [WORD_BITS-1:0]     mem_rd [WIN_SIZE-1];
    logic [WORD_BITS-1:0]     col_sr [WIN_SIZE][WIN_SIZE-1];
    logic [WORD_BITS-1:0]     cur [WIN_SIZE][WIN_SIZE];   // [0][0] is the newest sample
    logic [Y_BITS-1:0]        ctr_row;
    logic [X_BITS-1:0]        ctr_col;
    logic                     ctr_active;
    logic [2:0]               row_sel [WIN_SIZE];
    logic [2:0]               col_sel [WIN_SIZE];

    // mirror about the edge sample, returns the index into cur
    function automatic logic [2:0] refl_idx(input int pos, input int last, input int off);
        int p;
        p = pos + off;
        if (p < 0)
            p = -p;
        else if (p > last)
            p = 2 * last - p;
        return 3'(2 - (p - pos));
    endfunction

    assign sof      = s_valid && s_de && s_row_first && s_col_first;
    assign advance  = cke && s_valid && (state != WIN_IDLE || sof);
    assign line_end = (cnt_x == X_BITS'(frm_cols) + X_BITS'(HBLANK - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WIN_IDLE;
            cnt_x <= '0;
            cnt_y <= '0;
        end else if (advance) begin
            if (state == WIN_IDLE) begin
                state <= WIN_ACTIVE;
                cnt_x <= X_BITS'(1);
            end else if (line_end) begin
                cnt_x <= '0;
                cnt_y <= cnt_y + 1'b1;
                if (state == WIN_ACTIVE && cnt_y == Y_BITS'(frm_rows) - 1'b1) begin
                    state <= WIN_DRAIN;
                end else if (state == WIN_DRAIN &&
                             cnt_y == Y_BITS'(frm_rows) + Y_BITS'(VBLANK_LINES - 1)) begin
                    state <= WIN_IDLE;
                    cnt_y <= '0;
                end
            end else begin
                cnt_x <= cnt_x + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && state == WIN_IDLE) begin  // size is fixed for the whole frame
            frm_rows <= s_rows;
            frm_cols <= s_cols;
        end
    end

    // line memories form a vertical shift chain, blanking columns past the depth are dropped
    assign mem_addr = cnt_x[MEM_ADDR_BITS-1:0];
    assign wr_en    = advance && (cnt_x < X_BITS'(MAX_COLS));

    always_comb begin
        for (int k = 0; k < WIN_SIZE - 1; k++)
            mem_rd[k] = line_mem[k][mem_addr];
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[0][mem_addr] <= {s_user, s_data};
            for (int k = 1; k < WIN_SIZE - 1; k++)
                line_mem[k][mem_addr] <= mem_rd[k-1];
        end
    end

    always_comb begin
        cur[0][0] = {s_user, s_data};
        for (int i = 1; i < WIN_SIZE; i++)
            cur[i][0] = mem_rd[i-1];
        for (int i = 0; i < WIN_SIZE; i++)
            for (int j = 1; j < WIN_SIZE; j++)
                cur[i][j] = col_sr[i][j-1];
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < WIN_SIZE; i++)
                for (int j = 0; j < WIN_SIZE - 1; j++)
                    col_sr[i][j] <= cur[i][j];
        end
    end

    // centre sits two lines and two beats behind the input beat
    assign ctr_row    = cnt_y - Y_BITS'(2);
    assign ctr_col    = cnt_x - X_BITS'(2);
    assign ctr_active = (state != WIN_IDLE) && cnt_y >= Y_BITS'(2) && cnt_x >= X_BITS'(2) &&
                        ctr_row < Y_BITS'(frm_rows) && ctr_col < X_BITS'(frm_cols);

    always_comb begin
        for (int d = 0; d < WIN_SIZE; d++) begin
            row_sel[d] = ctr_active ? refl_idx(int'(ctr_row), int'(frm_rows) - 1, d - 2)
                                    : 3'(WIN_SIZE - 1 - d);
            col_sel[d] = ctr_active ? refl_idx(int'(ctr_col), int'(frm_cols) - 1, d - 2)
                                    : 3'(WIN_SIZE - 1 - d);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
            win_de    <= 1'b0;
        end else if (cke) begin
            win_valid <= advance;
            win_de    <= advance && ctr_active;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            for (int dy = 0; dy < WIN_SIZE; dy++)
                for (int dx = 0; dx < WIN_SIZE; dx++)
                    win_raw[dy][dx] <= cur[row_sel[dy]][col_sel[dx]][RAW_BITS-1:0];
            win_user      <= cur[2][2][WORD_BITS-1:RAW_BITS];
            win_rows      <= frm_rows;
            win_cols      <= frm_cols;
            win_row_first <= ctr_active && (ctr_row == '0);
            win_row_last  <= ctr_active && (ctr_row == Y_BITS'(frm_rows) - 1'b1);
            win_col_first <= ctr_active && (ctr_col == '0);
            win_col_last  <= ctr_active && (ctr_col == X_BITS'(frm_cols) - 1'b1);
        end
    end

    a_max_cols: assert property (@(posedge clk) disable iff (!rst_n)
        (cke && sof) |-> s_cols <= COLS_BITS'(MAX_COLS));

    a_min_size: assert property (@(posedge clk) disable iff (!rst_n)
        (cke && sof) |-> (s_rows >= ROWS_BITS'(3) && s_cols >= COLS_BITS'(3)));

    // line length may not change once the frame has started
    a_const_cols: assert property (@(posedge clk) disable iff (!rst_n)
        (advance && state != WIN_IDLE && s_de) |-> s_cols == frm_cols);

endmodule

`default_nettype wire

/* design/bayer_pkg.sv */
`default_nettype none

package bayer_pkg;

    // stream widths
    localparam int RAW_BITS  = 10;
    localparam int ROWS_BITS = 9;
    localparam int COLS_BITS = 9;
    localparam int USER_BITS = 1;

    // window buffer geometry
    localparam int MAX_COLS      = 256;
    localparam int WIN_SIZE      = 5;
    localparam int HBLANK        = 2;
    localparam int VBLANK_LINES  = 2;
    localparam int WORD_BITS     = USER_BITS + RAW_BITS;   // user rides along in the line memories
    localparam int MEM_ADDR_BITS = $clog2(MAX_COLS);
    localparam int X_BITS        = COLS_BITS + 1;          // padded raster column counter
    localparam int Y_BITS        = ROWS_BITS + 1;          // padded raster line counter

    // arithmetic
    localparam int CALC_LATENCY = 4;
    localparam int ROW_SUM_BITS = RAW_BITS + 2;
    localparam int SUM_BITS     = RAW_BITS + 4;

    typedef enum logic [1:0] {
        WIN_IDLE,    // waiting for a frame start
        WIN_ACTIVE,  // active lines of the frame
        WIN_DRAIN    // blank lines pushing out the last two rows
    } win_state_t;

endpackage

`default_nettype wire
